//--- raster_pkg.sv
package raster_pkg;

    ////////////////////////////////////////
    // Buffer geometry
    ////////////////////////////////////////

    localparam int buf_w      = 16;
    localparam int buf_h      = 12;
    localparam int pix_count  = buf_w * buf_h;
    localparam int addr_w     = 8;
    localparam int color_w    = 12;
    localparam int coord_w    = 4;
    localparam int rect_max   = 8;
    localparam int rect_idx_w = 3;

    ////////////////////////////////////////
    // APB map
    ////////////////////////////////////////

    localparam int apb_addr_w = 8;

    localparam logic [apb_addr_w-1:0] reg_ctrl      = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_bg        = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_status    = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_rect_base = 8'h20;

    // Frame-rate marker colours, alternating per frame
    localparam logic [color_w-1:0] marker_even = 12'h00F;
    localparam logic [color_w-1:0] marker_odd  = 12'hF00;

    ////////////////////////////////////////
    // Register layouts
    ////////////////////////////////////////

    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic [3:0]  rect_count;
        logic [1:0]  rsvd_lo;
        logic        ack;
        logic        start;
    } ctrl_fields_t;

    // Corners are inclusive
    typedef struct packed {
        logic [3:0]         rsvd;
        logic [color_w-1:0] color;
        logic [coord_w-1:0] y1;
        logic [coord_w-1:0] x1;
        logic [coord_w-1:0] y0;
        logic [coord_w-1:0] x0;
    } rect_entry_t;

    // One write word, decoded by target address
    typedef union packed {
        ctrl_fields_t ctrl;
        rect_entry_t  rect;
    } apb_word_u;

endpackage

//--- apb_regs.sv
module apb_regs (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [raster_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                       pwdata,
    input  raster_pkg::rect_entry_t           rd_entry,
    input  logic                              frame_done,
    input  logic [7:0]                        frame_cnt,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              tbl_we,
    output logic [raster_pkg::rect_idx_w-1:0] tbl_waddr,
    output raster_pkg::rect_entry_t           tbl_wdata,
    output logic [raster_pkg::rect_idx_w-1:0] rd_req_idx,
    output logic                              start_pulse,
    output logic                              ack_pulse,
    output logic [3:0]                        cfg_count,
    output logic [raster_pkg::color_w-1:0]    cfg_bg
);
    import raster_pkg::*;

    apb_word_u wword;
    logic      access;
    logic      wr_access;
    logic      hit_ctrl;
    logic      hit_bg;
    logic      hit_status;
    logic      hit_tbl;
    logic      running;

    assign wword     = pwdata;
    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign hit_ctrl   = (paddr == reg_ctrl);
    assign hit_bg     = (paddr == reg_bg);
    assign hit_status = (paddr == reg_status);
    assign hit_tbl    = (paddr >= reg_rect_base) &&
                        (paddr < reg_rect_base + 4 * rect_max) &&
                        (paddr[1:0] == 2'b00);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !(hit_ctrl || hit_bg || hit_status || hit_tbl);

    assign start_pulse = wr_access && hit_ctrl && wword.ctrl.start;
    assign ack_pulse   = wr_access && hit_ctrl && wword.ctrl.ack;

    // Table entry index from word offset
    assign tbl_we     = wr_access && hit_tbl;
    assign tbl_waddr  = paddr[rect_idx_w+1:2];
    assign rd_req_idx = paddr[rect_idx_w+1:2];

    always_comb begin
        tbl_wdata      = wword.rect;
        tbl_wdata.rsvd = '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg_count <= '0;
            cfg_bg    <= '0;
            running   <= 1'b0;
        end else begin
            if (wr_access && hit_ctrl) begin
                // Counts above the table size draw the whole table
                cfg_count <= (wword.ctrl.rect_count > 4'(rect_max)) ?
                             4'(rect_max) : wword.ctrl.rect_count;
            end
            if (wr_access && hit_bg) begin
                cfg_bg <= pwdata[color_w-1:0];
            end
            if (start_pulse) begin
                running <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[7:4] = cfg_count;
        end else if (hit_bg) begin
            prdata[color_w-1:0] = cfg_bg;
        end else if (hit_status) begin
            prdata[0]    = frame_done;
            prdata[1]    = running && !frame_done;
            prdata[15:8] = frame_cnt;
        end else if (hit_tbl) begin
            prdata = rd_entry;
        end
    end

endmodule

//--- rect_table.sv
module rect_table (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              we,
    input  logic [raster_pkg::rect_idx_w-1:0] waddr,
    input  raster_pkg::rect_entry_t           wdata,
    input  logic [raster_pkg::rect_idx_w-1:0] draw_idx,
    input  logic [raster_pkg::rect_idx_w-1:0] host_idx,
    output raster_pkg::rect_entry_t           draw_entry,
    output raster_pkg::rect_entry_t           host_entry
);
    import raster_pkg::*;

    rect_entry_t entries [rect_max];

    // Zeroed entries cover pixel 0,0 in colour 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < rect_max; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[waddr] <= wdata;
        end
    end

    // Draw side read, one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            draw_entry <= '0;
        end else begin
            draw_entry <= entries[draw_idx];
        end
    end

    // Host readback within the APB access
    assign host_entry = entries[host_idx];

endmodule

//--- pixel_scan.sv
module pixel_scan (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           load,
    input  logic [raster_pkg::coord_w-1:0] x0,
    input  logic [raster_pkg::coord_w-1:0] y0,
    input  logic [raster_pkg::coord_w-1:0] x1,
    input  logic [raster_pkg::coord_w-1:0] y1,
    output logic                           busy,
    output logic                           pix_valid,
    output logic [raster_pkg::addr_w-1:0]  addr,
    output logic                           last
);
    import raster_pkg::*;

    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [coord_w-1:0] x_start;
    logic [coord_w-1:0] x_end;
    logic [coord_w-1:0] y_end;
    logic               degen;
    logic               at_row_end;

    assign at_row_end = (x == x_end);
    assign pix_valid  = busy && !degen;

    // Empty rectangle ends at once with no pixel
    assign last = busy && (degen || (at_row_end && (y == y_end)));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy    <= 1'b0;
            degen   <= 1'b0;
            x       <= '0;
            y       <= '0;
            x_start <= '0;
            x_end   <= '0;
            y_end   <= '0;
            addr    <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            degen   <= (x1 < x0) || (y1 < y0);
            x       <= x0;
            y       <= y0;
            x_start <= x0;
            x_end   <= x1;
            y_end   <= y1;
            addr    <= addr_w'(y0) * addr_w'(buf_w) + addr_w'(x0);
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
            end else if (at_row_end) begin
                // Back to the left edge of the next row
                x    <= x_start;
                y    <= y + 1'b1;
                addr <= addr + addr_w'(buf_w) - addr_w'(x_end - x_start);
            end else begin
                x    <= x + 1'b1;
                addr <= addr + 1'b1;
            end
        end
    end

endmodule

//--- frame_ctrl.sv
module frame_ctrl (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start_pulse,
    input  logic                              ack_pulse,
    input  logic [3:0]                        cfg_count,
    input  logic [raster_pkg::color_w-1:0]    cfg_bg,
    input  raster_pkg::rect_entry_t           draw_entry,
    input  logic                              scan_busy,
    input  logic                              scan_valid,
    input  logic [raster_pkg::addr_w-1:0]     scan_addr,
    input  logic                              scan_last,
    output logic [raster_pkg::rect_idx_w-1:0] draw_idx,
    output logic                              scan_load,
    output logic [raster_pkg::coord_w-1:0]    scan_x0,
    output logic [raster_pkg::coord_w-1:0]    scan_y0,
    output logic [raster_pkg::coord_w-1:0]    scan_x1,
    output logic [raster_pkg::coord_w-1:0]    scan_y1,
    output logic                              write_en,
    output logic [raster_pkg::addr_w-1:0]     write_addr,
    output logic [raster_pkg::color_w-1:0]    write_data,
    output logic                              frame_done,
    output logic [7:0]                        frame_cnt
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        idle,
        clear,
        fetch,
        paint,
        marker,
        done
    } state_t;

    state_t              state;
    logic [addr_w-1:0]   clr_addr;
    logic [rect_idx_w-1:0] ent_idx;
    logic                fetch_wait;
    logic [3:0]          count_q;
    logic [color_w-1:0]  bg_q;
    logic [color_w-1:0]  color_q;
    logic                frame_begin;
    logic                last_entry;

    assign frame_begin = ((state == idle) && start_pulse) || ((state == done) && ack_pulse);
    assign last_entry  = (({1'b0, ent_idx} + 4'd1) == count_q);

    assign draw_idx   = ent_idx;
    assign scan_load  = (state == fetch) && fetch_wait;
    assign scan_x0    = draw_entry.x0;
    assign scan_y0    = draw_entry.y0;
    assign scan_x1    = draw_entry.x1;
    assign scan_y1    = draw_entry.y1;
    assign frame_done = (state == done);

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= idle;
            clr_addr   <= '0;
            ent_idx    <= '0;
            fetch_wait <= 1'b0;
            count_q    <= '0;
            bg_q       <= '0;
            color_q    <= '0;
            frame_cnt  <= '0;
        end else begin
            if (frame_begin) begin
                state    <= clear;
                bg_q     <= cfg_bg;
                clr_addr <= '0;
                ent_idx  <= '0;
            end
            case (state)
                clear: begin
                    // Count taken after a start write with a new count has landed
                    if (clr_addr == '0) begin
                        count_q <= cfg_count;
                    end
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == addr_w'(pix_count - 1)) begin
                        state <= (count_q == '0) ? marker : fetch;
                    end
                end
                fetch: begin
                    // Table read, then scan load
                    fetch_wait <= !fetch_wait;
                    if (fetch_wait) begin
                        color_q <= draw_entry.color;
                        state   <= paint;
                    end
                end
                paint: begin
                    if (scan_busy && scan_last) begin
                        ent_idx <= ent_idx + 1'b1;
                        state   <= last_entry ? marker : fetch;
                    end
                end
                marker: begin
                    frame_cnt <= frame_cnt + 1'b1;
                    state     <= done;
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Pixel port mux
    ////////////////////////////////////////

    always_comb begin
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        case (state)
            clear: begin
                write_en   = 1'b1;
                write_addr = clr_addr;
                write_data = bg_q;
            end
            paint: begin
                write_en   = scan_valid;
                write_addr = scan_addr;
                write_data = color_q;
            end
            marker: begin
                // Last pixel toggles each frame
                write_en   = 1'b1;
                write_addr = addr_w'(pix_count - 1);
                write_data = frame_cnt[0] ? marker_odd : marker_even;
            end
            default: ;
        endcase
    end

endmodule

//--- raster_top.sv
module raster_top (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [raster_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              write_en,
    output logic [raster_pkg::addr_w-1:0]     write_addr,
    output logic [raster_pkg::color_w-1:0]    write_data
);
    import raster_pkg::*;

    logic                  tbl_we;
    logic [rect_idx_w-1:0] tbl_waddr;
    rect_entry_t           tbl_wdata;
    logic [rect_idx_w-1:0] rd_req_idx;
    rect_entry_t           host_entry;
    logic [rect_idx_w-1:0] draw_idx;
    rect_entry_t           draw_entry;
    logic                  start_pulse;
    logic                  ack_pulse;
    logic [3:0]            cfg_count;
    logic [color_w-1:0]    cfg_bg;
    logic                  scan_load;
    logic [coord_w-1:0]    scan_x0;
    logic [coord_w-1:0]    scan_y0;
    logic [coord_w-1:0]    scan_x1;
    logic [coord_w-1:0]    scan_y1;
    logic                  scan_busy;
    logic                  scan_valid;
    logic [addr_w-1:0]     scan_addr;
    logic                  scan_last;
    logic                  frame_done;
    logic [7:0]            frame_cnt;

    apb_regs u_apb_regs (
        .clk         (clk),
        .rstn        (rstn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .rd_entry    (host_entry),
        .frame_done  (frame_done),
        .frame_cnt   (frame_cnt),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .tbl_we      (tbl_we),
        .tbl_waddr   (tbl_waddr),
        .tbl_wdata   (tbl_wdata),
        .rd_req_idx  (rd_req_idx),
        .start_pulse (start_pulse),
        .ack_pulse   (ack_pulse),
        .cfg_count   (cfg_count),
        .cfg_bg      (cfg_bg)
    );

    rect_table u_rect_table (
        .clk        (clk),
        .rstn       (rstn),
        .we         (tbl_we),
        .waddr      (tbl_waddr),
        .wdata      (tbl_wdata),
        .draw_idx   (draw_idx),
        .host_idx   (rd_req_idx),
        .draw_entry (draw_entry),
        .host_entry (host_entry)
    );

    pixel_scan u_pixel_scan (
        .clk       (clk),
        .rstn      (rstn),
        .load      (scan_load),
        .x0        (scan_x0),
        .y0        (scan_y0),
        .x1        (scan_x1),
        .y1        (scan_y1),
        .busy      (scan_busy),
        .pix_valid (scan_valid),
        .addr      (scan_addr),
        .last      (scan_last)
    );

    frame_ctrl u_frame_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .start_pulse (start_pulse),
        .ack_pulse   (ack_pulse),
        .cfg_count   (cfg_count),
        .cfg_bg      (cfg_bg),
        .draw_entry  (draw_entry),
        .scan_busy   (scan_busy),
        .scan_valid  (scan_valid),
        .scan_addr   (scan_addr),
        .scan_last   (scan_last),
        .draw_idx    (draw_idx),
        .scan_load   (scan_load),
        .scan_x0     (scan_x0),
        .scan_y0     (scan_y0),
        .scan_x1     (scan_x1),
        .scan_y1     (scan_y1),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .frame_done  (frame_done),
        .frame_cnt   (frame_cnt)
    );

endmodule

//--- tb_raster.sv
module tb_raster;
    import raster_pkg::*;

    localparam int frame_limit = 5000;

    logic               clk;
    logic               rstn;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic               write_en;
    logic [addr_w-1:0]  write_addr;
    logic [color_w-1:0] write_data;

    // External frame buffer
    logic [color_w-1:0] fb [pix_count];
    int                 cycle_cnt = 0;

    raster_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Frame buffer model takes every pixel write
    always @(negedge clk) begin
        if (rstn && write_en === 1'b1) begin
            if (write_addr >= addr_w'(pix_count)) begin
                stop_with("A pixel write fell outside the frame buffer");
            end else begin
                fb[write_addr] = write_data;
            end
        end
    end

    ////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Access phase completes in its first cycle
        @(negedge clk);
        check_value("pready", {31'h0, pready}, 32'h1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Poll status until the frame is done
    task automatic wait_frame();
        logic [31:0] status;
        logic        err;
        int          t0;
        t0     = cycle_cnt;
        status = '0;
        while (status[0] !== 1'b1) begin
            if (cycle_cnt - t0 > frame_limit) begin
                stop_with("Timed out waiting for the frame to finish");
            end
            apb_access(1'b0, reg_status, 32'h0, status, err);
            check_value("pslverr on status poll", {31'h0, err}, 32'h0);
        end
    endtask

    ////////////////////////////////////////
    // Command interpreter
    ////////////////////////////////////////

    initial begin
        int            fd;
        int            n;
        int            n_cmds;
        logic [127:0]  cmd;
        logic [1023:0] line;
        logic [31:0]   a;
        logic [31:0]   d;
        logic [31:0]   rdata;
        logic          err;
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        n_cmds  = 0;
        for (int i = 0; i < pix_count; i++) begin
            fb[i] = 12'hE00 + 12'(i);
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        fd = $fopen("raster_tests.txt", "r");
        if (fd == 0) begin
            stop_with("Could not open raster_tests.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", cmd);
            if (n == 1) begin
                case (cmd)
                    "#": n = $fgets(line, fd);
                    "W": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        apb_access(1'b1, a[7:0], d, rdata, err);
                        check_value($sformatf("pslverr write %h", a[7:0]), {31'h0, err}, 32'h0);
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        apb_access(1'b0, a[7:0], 32'h0, rdata, err);
                        check_value($sformatf("pslverr read %h", a[7:0]), {31'h0, err}, 32'h0);
                        check_value($sformatf("prdata %h", a[7:0]), rdata, d);
                    end
                    "U": begin
                        n = $fscanf(fd, "%h", a);
                        apb_access(1'b0, a[7:0], 32'h0, rdata, err);
                        check_value($sformatf("pslverr read %h", a[7:0]), {31'h0, err}, 32'h1);
                        check_value($sformatf("prdata %h", a[7:0]), rdata, 32'h0);
                    end
                    "F": wait_frame();
                    "P": begin
                        n = $fscanf(fd, "%d %h", a, d);
                        if (a >= pix_count) begin
                            stop_with("Pixel index in the test file is out of range");
                        end
                        check_value($sformatf("pixel %0d", a), {20'h0, fb[a]}, d);
                    end
                    "A": begin
                        // Ack keeps the count field of the control word
                        n = $fscanf(fd, "%h", d);
                        apb_access(1'b1, reg_ctrl, {d[27:0], 4'h0} | 32'h2, rdata, err);
                        check_value("pslverr on ack", {31'h0, err}, 32'h0);
                    end
                    default: stop_with($sformatf("Unknown command %0s in test file", cmd));
                endcase
                n_cmds++;
            end
        end
        $fclose(fd);

        if (n_cmds == 0) begin
            stop_with("The test file held no commands");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- raster_tests.txt
# W addr data | R addr expected | U addr (unmapped read) | A count (ack)
# F (wait for frame done) | P pixel expected, pixel decimal, other fields hex
R 00 0
R 04 0
R 08 0
R 20 0
R 3C 0
U 0C
U 21
U 40
W 04 123
W 00 1
R 08 2
F
P 0 123
P 100 123
P 190 123
P 191 00F
R 08 101
W 20 0A114612
W 24 0B227935
W 28 0C332328
W 2C 0D44BF0F
W 30 0EEEBF00
R 24 0B227935
W 04 456
W 00 40
P 0 123
R 04 456
A 4
R 00 40
R 08 102
F
P 0 456
P 18 A11
P 66 A11
P 52 A11
P 53 B22
P 70 B22
P 121 B22
P 40 456
P 15 D44
P 175 D44
P 176 456
P 156 456
P 191 F00
R 08 201

//--- raster.f
raster_pkg.sv
apb_regs.sv
rect_table.sv
pixel_scan.sv
frame_ctrl.sv
raster_top.sv
tb_raster.sv

//--- run_sim.sh
#!/bin/bash
# Build the raster testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_raster -f raster.f -o sim_raster \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_raster > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log

grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"
